// ==== compile.f ====
verilog/cache_cfg_pkg.sv
verilog/axi_pkg.sv
verilog/write_buffer.sv
verilog/cache_write_channel_axi.sv
verilog/cache_write_path.sv
sim/axi_mem_model.sv
sim/tb_cache_write_path.sv

// ==== sim/tb_cache_write_path.sv ====
`timescale 1ns/1ns

module tb_cache_write_path;

    import cache_cfg_pkg::*;
    import axi_pkg::*;

    localparam int N_STORES    = 20;
    localparam int WORST_STORE = 2 * (2 + 2 * 16);    // failed try plus retry at max stall
    localparam int MAX_CYCLES  = 16 + N_STORES * WORST_STORE + 200;

    logic                 clk;
    logic                 reset;
    logic                 cpu_valid;
    logic [ADDR_W-1:0]    cpu_addr;
    logic [DATA_W-1:0]    cpu_wdata;
    logic [NBYTES-1:0]    cpu_wstrb;
    logic                 cpu_ready;
    logic                 drained;
    logic                 awvalid, awready, awlock;
    logic [ADDR_W-1:0]    awaddr;
    logic [7:0]           awlen;
    logic [2:0]           awsize, awprot;
    axi_burst_e           awburst;
    logic [3:0]           awcache, awqos;
    logic [AXI_ID_W-1:0]  awid;
    logic                 wvalid, wready, wlast;
    logic [BE_DATA_W-1:0] wdata;
    logic [BE_NBYTES-1:0] wstrb;
    logic                 bvalid, bready;
    axi_resp_e            bresp;
    logic [3:0]           ready_delay;
    logic [63:0]          err_mask;

    logic [7:0]        image [256];       // expected memory bytes
    logic [ADDR_W-1:0] exp_aw [$];
    logic [ADDR_W-1:0] port_aw [$];
    logic [7:0]        exp_ws [$];
    logic [7:0]        port_ws [$];
    logic [15:0]       lfsr;
    logic              saw_full;
    int                pending;           // accepted stores not yet answered okay
    int                errors;
    int                mark;
    int                stores;
    int                cycles;
    int                passed;
    int                failed;

    cache_write_path u_cache_write_path (.*);
    axi_mem_model u_axi_mem_model (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // handshakes happen at the next rising edge
    always @(negedge clk) begin
        check(cpu_ready, pending < 2**WBUF_DEPTH_W, "cpu_ready against pending stores");
        if (cpu_valid && cpu_ready) begin
            pending++;
        end
        if (bvalid && bready && bresp == OKAY) begin
            pending--;                    // entry leaves the buffer
        end
        if (awvalid && awready) begin
            port_aw.push_back(awaddr);
            check(awlen, 0, "awlen not single beat");
            check(awburst, FIXED, "awburst not FIXED");
            check(awsize, 3, "awsize not full bus");
            check(awid, AXI_ID, "awid");
            check(awcache, AXI_CACHE_ATTR, "awcache");
            check(awlock, 0, "awlock not normal access");
            check(awprot, 0, "awprot");
            check(awqos, 0, "awqos");
        end
        if (wvalid) begin
            check(wlast, 1, "wlast low with wvalid");
        end
        if (wvalid && wready) begin
            port_ws.push_back(wstrb);
        end
    end

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic post_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic taken;
        taken       = 1'b0;
        ready_delay = random_bits(2);
        cpu_valid   = 1'b1;
        cpu_addr    = addr;
        cpu_wdata   = data;
        cpu_wstrb   = strb;
        while (!taken) begin
            @(negedge clk);
            taken    = cpu_ready;
            saw_full = saw_full || !cpu_ready;
            @(posedge clk);
            #2;
        end
        cpu_valid = 1'b0;
        for (int b = 0; b < NBYTES; b++) begin
            if (strb[b]) begin
                image[{addr[7:2], 2'b00} + b] = data[8*b +: 8];
            end
        end
        repeat (err_mask[stores] ? 2 : 1) begin      // a failed try is sent again
            exp_aw.push_back({addr[31:3], 3'b000});
            exp_ws.push_back(8'(strb) << (4 * addr[2]));
        end
        stores++;
    endtask

    task automatic drain_and_compare(input string name);
        @(negedge clk);
        while (!drained) begin
            @(negedge clk);
        end
        check(port_aw.size(), exp_aw.size(), "AW count at ports");
        check(port_ws.size(), exp_ws.size(), "W count at ports");
        check(u_axi_mem_model.aw_count, exp_aw.size(), "AW count in model");
        for (int i = 0; i < exp_aw.size() && i < port_aw.size() && i < port_ws.size(); i++) begin
            check(port_aw[i], exp_aw[i], "AW address order");
            check(u_axi_mem_model.aw_log[i], exp_aw[i], "model AW log");
            check(port_ws[i], exp_ws[i], "W strobes");
        end
        for (int a = 0; a < 256; a++) begin
            check(u_axi_mem_model.mem[a], image[a], $sformatf("memory byte %h", a));
        end
        if (errors == mark) begin
            passed++;
            $display("test %s ok", name);
        end else begin
            failed++;
            $display("test %s had %0d errors", name, errors - mark);
        end
        mark = errors;
        @(posedge clk);
        #2;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        lfsr        = 16'd73;
        cpu_valid   = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_wstrb   = '0;
        ready_delay = 4'd0;
        err_mask    = '0;
        saw_full    = 1'b0;
        for (int a = 0; a < 256; a++) begin
            image[a] = 8'h00;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        @(negedge clk);
        check(awvalid, 0, "awvalid after reset");
        check(wvalid, 0, "wvalid after reset");
        check(bready, 0, "bready after reset");
        check(cpu_ready, 1, "cpu_ready after reset");
        check(drained, 1, "drained after reset");
        drain_and_compare("reset_state");

        post_store(32'h10, random_bits(32), 4'hf);   // lower lane
        post_store(32'h1c, random_bits(32), 4'hf);   // upper lane
        drain_and_compare("lane_select");

        post_store(32'h40, random_bits(32), 4'hf);
        post_store(32'h44, random_bits(32), 4'hf);
        post_store(32'h41, random_bits(32), 4'b0010);
        post_store(32'h46, random_bits(32), 4'b1100);
        drain_and_compare("partial_strobe");

        saw_full = 1'b0;
        for (int i = 0; i < 8; i++) begin
            post_store(32'h80 + 4 * i, random_bits(32), 4'hf);
        end
        check(saw_full, 1, "cpu_ready never dropped with four stores pending");
        drain_and_compare("burst_backpressure");

        for (int i = 0; i < 6; i++) begin
            err_mask[stores] = (i == 0 || i == 2 || i == 5);
            post_store(32'hc0 + 4 * i, random_bits(32), 4'hf);
        end
        drain_and_compare("error_retry");

        $display("tests passed %0d failed %0d", passed, failed);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model (
    input  logic                                clk,
    input  logic [3:0]                          ready_delay,  // stall cycles per channel
    input  logic [63:0]                         err_mask,     // stores whose first try fails
    input  logic                                awvalid,
    input  logic [cache_cfg_pkg::ADDR_W-1:0]    awaddr,
    output logic                                awready,
    input  logic                                wvalid,
    input  logic [cache_cfg_pkg::BE_DATA_W-1:0] wdata,
    input  logic [cache_cfg_pkg::BE_NBYTES-1:0] wstrb,
    output logic                                wready,
    output logic                                bvalid,
    output axi_pkg::axi_resp_e                  bresp,
    input  logic                                bready
);

    import cache_cfg_pkg::*;
    import axi_pkg::*;

    logic [7:0]        mem [256];               // low address byte selects
    logic [ADDR_W-1:0] aw_log [64];             // aw addresses in issue order
    logic [ADDR_W-1:0] cur_addr;
    int                aw_count;
    int                ok_count;                // stores answered okay so far
    int                stall;
    logic [3:0]        delay;                   // ready delay seen at the edge
    logic              retrying;
    logic              took_aw;
    logic              took_w;
    logic              took_b;
    logic              fail;

    initial begin
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        bresp    = OKAY;
        aw_count = 0;
        ok_count = 0;
        stall    = 0;
        retrying = 1'b0;
        fail     = 1'b0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'h00;
        end
    end

    always @(posedge clk) begin
        delay   = ready_delay;
        took_aw = awvalid && awready;
        took_w  = wvalid && wready;
        took_b  = bvalid && bready;
        if (took_aw) begin
            aw_log[aw_count] = awaddr;
            aw_count++;
            cur_addr = awaddr;
        end
        if (took_w) begin
            fail = err_mask[ok_count] && !retrying;    // first attempt only
            for (int b = 0; b < BE_NBYTES; b++) begin
                if (wstrb[b] && !fail) begin
                    mem[8'(cur_addr[7:0] + b)] = wdata[8*b +: 8];
                end
            end
        end
        if (took_b) begin
            retrying = (bresp != OKAY);
            if (bresp == OKAY) begin
                ok_count++;
            end
        end
        if (took_aw || took_w) begin
            stall = 0;                                 // next channel starts fresh
        end
        #2;
        stall   = (awvalid || wvalid) ? stall + 1 : 0;
        awready = awvalid && (stall > delay);
        wready  = wvalid && (stall > delay);
        if (took_w) begin
            bvalid = 1'b1;
            bresp  = fail ? SLVERR : OKAY;
        end else if (took_b) begin
            bvalid = 1'b0;
        end
    end

endmodule

// ==== verilog/cache_write_path.sv ====
`timescale 1ns/1ns

module cache_write_path (
    input  logic                                 clk,
    input  logic                                 reset,

    // cpu store port
    input  logic                                 cpu_valid,
    input  logic [cache_cfg_pkg::ADDR_W-1:0]     cpu_addr,
    input  logic [cache_cfg_pkg::DATA_W-1:0]     cpu_wdata,
    input  logic [cache_cfg_pkg::NBYTES-1:0]     cpu_wstrb,
    output logic                                 cpu_ready,
    output logic                                 drained,

    // axi address write
    output logic                                 awvalid,
    output logic [cache_cfg_pkg::ADDR_W-1:0]     awaddr,
    output logic [7:0]                           awlen,
    output logic [2:0]                           awsize,
    output axi_pkg::axi_burst_e                  awburst,
    output logic                                 awlock,
    output logic [3:0]                           awcache,
    output logic [2:0]                           awprot,
    output logic [3:0]                           awqos,
    output logic [axi_pkg::AXI_ID_W-1:0]         awid,
    input  logic                                 awready,

    // axi write data
    output logic                                 wvalid,
    output logic [cache_cfg_pkg::BE_DATA_W-1:0]  wdata,
    output logic [cache_cfg_pkg::BE_NBYTES-1:0]  wstrb,
    output logic                                 wlast,
    input  logic                                 wready,

    // axi write response
    input  logic                                 bvalid,
    input  axi_pkg::axi_resp_e                   bresp,
    output logic                                 bready
);

    import cache_cfg_pkg::*;

    logic              push;
    logic              full;
    logic              pop;
    logic              head_valid;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_wdata;
    logic [NBYTES-1:0] head_wstrb;

    assign cpu_ready = !full;
    assign push      = cpu_valid && cpu_ready;  // store accepted this cycle

    write_buffer u_write_buffer (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_addr  (cpu_addr),
        .push_wdata (cpu_wdata),
        .push_wstrb (cpu_wstrb),
        .full       (full),
        .pop        (pop),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wstrb (head_wstrb)
    );

    cache_write_channel_axi u_write_channel (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wstrb (head_wstrb),
        .pop        (pop),
        .drained    (drained),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .awlock     (awlock),
        .awcache    (awcache),
        .awprot     (awprot),
        .awqos      (awqos),
        .awid       (awid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready)
    );

endmodule

// ==== verilog/cache_write_channel_axi.sv ====
`timescale 1ns/1ns

module cache_write_channel_axi (
    input  logic                                 clk,
    input  logic                                 reset,

    // write buffer head
    input  logic                                 head_valid,
    input  logic [cache_cfg_pkg::ADDR_W-1:0]     head_addr,
    input  logic [cache_cfg_pkg::DATA_W-1:0]     head_wdata,
    input  logic [cache_cfg_pkg::NBYTES-1:0]     head_wstrb,
    output logic                                 pop,
    output logic                                 drained,

    // address write
    output logic                                 awvalid,
    output logic [cache_cfg_pkg::ADDR_W-1:0]     awaddr,
    output logic [7:0]                           awlen,
    output logic [2:0]                           awsize,
    output axi_pkg::axi_burst_e                  awburst,
    output logic                                 awlock,
    output logic [3:0]                           awcache,
    output logic [2:0]                           awprot,
    output logic [3:0]                           awqos,
    output logic [axi_pkg::AXI_ID_W-1:0]         awid,
    input  logic                                 awready,

    // write data
    output logic                                 wvalid,
    output logic [cache_cfg_pkg::BE_DATA_W-1:0]  wdata,
    output logic [cache_cfg_pkg::BE_NBYTES-1:0]  wstrb,
    output logic                                 wlast,
    input  logic                                 wready,

    // write response
    input  logic                                 bvalid,
    input  axi_pkg::axi_resp_e                   bresp,
    output logic                                 bready
);

    import cache_cfg_pkg::*;
    import axi_pkg::*;

    wr_state_e state;
    wr_state_e state_next;

    logic [BE_NBYTES_W-NBYTES_W-1:0] lane;     // word position inside the beat
    logic                            resp_ok;

    // single beat, fixed attributes
    assign awlen   = 8'd0;
    assign awsize  = 3'(BE_NBYTES_W);          // full bus width per beat
    assign awburst = FIXED;
    assign awlock  = 1'b0;                     // normal access
    assign awcache = AXI_CACHE_ATTR;
    assign awprot  = 3'd0;
    assign awqos   = 4'd0;
    assign awid    = AXI_ID;
    assign wlast   = wvalid;

    // beat aligned address
    assign awaddr = {head_addr[ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}};

    assign lane  = head_addr[BE_NBYTES_W-1:NBYTES_W];
    assign wdata = {(BE_DATA_W/DATA_W){head_wdata}};    // word copied to every lane
    assign wstrb = BE_NBYTES'(head_wstrb) << (lane * NBYTES);

    assign resp_ok = (bresp == OKAY);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= WR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE: begin
                if (head_valid) begin
                    state_next = WR_ADDRESS;
                end
            end
            WR_ADDRESS: begin
                if (awready) begin
                    state_next = WR_WRITE;
                end
            end
            WR_WRITE: begin
                if (wready) begin
                    state_next = WR_VERIFY;
                end
            end
            WR_VERIFY: begin
                if (bvalid && resp_ok) begin
                    state_next = WR_IDLE;
                end else if (bvalid) begin
                    state_next = WR_ADDRESS;   // error, resend same entry
                end
            end
            default: state_next = WR_IDLE;
        endcase
    end

    always_comb begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        pop     = 1'b0;
        case (state)
            WR_ADDRESS: awvalid = 1'b1;
            WR_WRITE:   wvalid  = 1'b1;
            WR_VERIFY: begin
                bready = 1'b1;
                pop    = bvalid && resp_ok;    // entry retires only on okay
            end
            default: ;
        endcase
    end

    assign drained = (state == WR_IDLE) && !head_valid;

endmodule

// ==== verilog/write_buffer.sv ====
`timescale 1ns/1ns

module write_buffer (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              push,
    input  logic [cache_cfg_pkg::ADDR_W-1:0]  push_addr,
    input  logic [cache_cfg_pkg::DATA_W-1:0]  push_wdata,
    input  logic [cache_cfg_pkg::NBYTES-1:0]  push_wstrb,
    output logic                              full,

    input  logic                              pop,
    output logic                              head_valid,
    output logic [cache_cfg_pkg::ADDR_W-1:0]  head_addr,
    output logic [cache_cfg_pkg::DATA_W-1:0]  head_wdata,
    output logic [cache_cfg_pkg::NBYTES-1:0]  head_wstrb
);

    import cache_cfg_pkg::*;

    // entry storage
    logic [ADDR_W-1:0] addr_mem [2**WBUF_DEPTH_W];
    logic [DATA_W-1:0] data_mem [2**WBUF_DEPTH_W];
    logic [NBYTES-1:0] strb_mem [2**WBUF_DEPTH_W];

    logic [WBUF_DEPTH_W-1:0] wr_ptr;
    logic [WBUF_DEPTH_W-1:0] rd_ptr;
    logic [WBUF_DEPTH_W:0]   count;            // one extra bit for full

    logic wr_en;
    logic rd_en;

    assign full       = (count == (WBUF_DEPTH_W+1)'(2**WBUF_DEPTH_W));
    assign head_valid = (count != '0);

    assign wr_en = push && !full;              // never overwrite the head
    assign rd_en = pop;

    // first word falls through
    assign head_addr  = addr_mem[rd_ptr];
    assign head_wdata = data_mem[rd_ptr];
    assign head_wstrb = strb_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_wdata;
            strb_mem[wr_ptr] <= push_wstrb;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;       // wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

endmodule

// ==== verilog/axi_pkg.sv ====
package axi_pkg;

    localparam int AXI_ID_W = 1;
    localparam logic [AXI_ID_W-1:0] AXI_ID = '0;    // single fixed id

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // normal non-cacheable bufferable
    localparam logic [3:0] AXI_CACHE_ATTR = 4'b0011;

    // write channel engine
    typedef enum logic [1:0] {
        WR_IDLE    = 2'd0,
        WR_ADDRESS = 2'd1,
        WR_WRITE   = 2'd2,
        WR_VERIFY  = 2'd3
    } wr_state_e;

endpackage

// ==== verilog/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    // cpu side
    localparam int ADDR_W = 32;                 // byte address
    localparam int DATA_W = 32;                 // cache word

    localparam int NBYTES = DATA_W / 8;         // bytes per cache word
    localparam int NBYTES_W = $clog2(NBYTES);

    // memory side
    localparam int BE_DATA_W = 64;              // memory bus width

    localparam int BE_NBYTES = BE_DATA_W / 8;   // bytes per memory beat
    localparam int BE_NBYTES_W = $clog2(BE_NBYTES);

    // write buffer
    localparam int WBUF_DEPTH_W = 2;            // four entries

endpackage
